/* mcu_control_store.sv */
`timescale 1ns/100ps

module mcu_control_store (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [mcu_pkg::UADDR_W-1:0] i_uaddr,
    output mcu_pkg::micro_word_t        o_uword,
    output logic                        o_uvalid,
    mcu_host_if.store                   host_if
);

logic [mcu_pkg::UWORD_W-1:0] mem [2**mcu_pkg::UADDR_W];   // Microcode RAM

// Host load port
always_ff @(posedge clk) begin
    if (host_if.ucode_we) begin
        mem[host_if.ucode_addr] <= host_if.ucode_data;
    end
end

// Pipeline register, fetch while running
always_ff @(posedge clk) begin
    if (host_if.running) begin
        o_uword <= mem[i_uaddr];
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        o_uvalid <= 1'b0;
    end else begin
        o_uvalid <= host_if.running;            // Word valid one cycle after fetch
    end
end

endmodule

/* mcu_host_if.sv */
`timescale 1ns/100ps

interface mcu_host_if;
    logic                          ucode_we;     // Store write strobe
    logic [mcu_pkg::UADDR_W-1:0]   ucode_addr;   // Load pointer
    logic [mcu_pkg::UWORD_W-1:0]   ucode_data;   // Word to store
    logic                          start;        // One-cycle pulse
    logic                          stop;         // One-cycle pulse
    logic                          running;
    logic                          halted;
    logic [11:0]                   mode_word;    // {emul, tkk, tr1, tr0, mode}
    logic                          xmem_we;      // Core write to exchange memory
    logic [mcu_pkg::XADDR_W-1:0]   xmem_addr;
    logic [mcu_pkg::YBUS_W-1:0]    xmem_data;

    modport regs (
        output ucode_we, ucode_addr, ucode_data, start, stop,
        input  running, halted, mode_word, xmem_we, xmem_addr, xmem_data
    );

    modport store (
        input ucode_we, ucode_addr, ucode_data, running
    );

    modport seq (
        input  start, stop,
        output running, halted
    );

    modport unit (
        input  running,
        output mode_word, xmem_we, xmem_addr, xmem_data
    );
endinterface

/* mcu_host_regs.sv */
`timescale 1ns/100ps

module mcu_host_regs (
    input  logic        clk,
    input  logic        reset,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [7:0]  i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pslverr,
    mcu_host_if.regs    host_if
);

logic access;                                   // APB access phase
logic wr;                                       // Write access
logic rd;                                       // Read access
logic load_sel;                                 // UADDR or UDATA hit
logic load_ok;                                  // Load allowed, core idle
logic xmem_sel;                                 // Exchange memory window
logic [mcu_pkg::UADDR_W-1:0] load_ptr;          // Auto-increment pointer
logic [mcu_pkg::YBUS_W-1:0]  xmem [mcu_pkg::XMEM_DEPTH];

assign access   = i_psel & i_penable;
assign wr       = access & i_pwrite;
assign rd       = access & ~i_pwrite;
assign load_sel = (i_paddr == mcu_pkg::REG_UADDR) | (i_paddr == mcu_pkg::REG_UDATA);
assign load_ok  = ~host_if.running;
assign xmem_sel = (i_paddr[7:6] == mcu_pkg::REG_XMEM_BASE[7:6]) & (i_paddr[1:0] == 2'b00);

// --------------------
// Control pulses and microcode load
assign host_if.start = wr & (i_paddr == mcu_pkg::REG_CTRL) & i_pwdata[0];
assign host_if.stop  = wr & (i_paddr == mcu_pkg::REG_CTRL) & i_pwdata[1];

assign host_if.ucode_we   = wr & (i_paddr == mcu_pkg::REG_UDATA) & load_ok;
assign host_if.ucode_addr = load_ptr;
assign host_if.ucode_data = i_pwdata;

assign o_pslverr = wr & load_sel & ~load_ok;    // Load while running

always_ff @(posedge clk) begin
    if (reset) begin
        load_ptr <= '0;
    end else if (wr & load_ok) begin
        if (i_paddr == mcu_pkg::REG_UADDR) begin
            load_ptr <= i_pwdata[mcu_pkg::UADDR_W-1:0];  // New load origin
        end else if (i_paddr == mcu_pkg::REG_UDATA) begin
            load_ptr <= load_ptr + 1'b1;                // Step past stored word
        end
    end
end

// --------------------
// Exchange memory, core writes, host reads
always_ff @(posedge clk) begin
    if (reset) begin
        for (int i = 0; i < mcu_pkg::XMEM_DEPTH; i++) begin
            xmem[i] <= '0;                      // Host sees zeros until written
        end
    end else if (host_if.xmem_we) begin
        xmem[host_if.xmem_addr] <= host_if.xmem_data;
    end
end

// --------------------
// Read mux
always_comb begin
    o_prdata = '0;                              // Unmapped reads zero
    if (rd) begin
        if (xmem_sel) begin
            o_prdata = {24'd0, xmem[i_paddr[2 +: mcu_pkg::XADDR_W]]};
        end else begin
            case (i_paddr)
                mcu_pkg::REG_CTRL: o_prdata = {30'd0, host_if.halted, host_if.running};
                mcu_pkg::REG_MODE: o_prdata = {20'd0, host_if.mode_word};
                default:           o_prdata = '0;
            endcase
        end
    end
end

endmodule

/* mcu_mode_unit.sv */
`timescale 1ns/100ps

module mcu_mode_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  mcu_pkg::micro_word_t i_uword,
    input  logic                 i_uvalid,
    output logic                 o_cond,
    mcu_host_if.unit             host_if
);

logic [mcu_pkg::YBUS_W-1:0]  y_bus;             // Y bus
logic [mcu_pkg::YBUS_W-1:0]  mode_q;            // Mode register
logic [mcu_pkg::XADDR_W-1:0] xptr;              // Exchange write pointer
logic tr0, tr1;                                 // Microprogram flags
logic tkk;                                      // Right-half command flag
logic emul;                                     // Emulation mode
logic condmux;
logic exec;

assign exec  = i_uvalid & host_if.running;
assign y_bus = (i_uword.ysrc == mcu_pkg::YSRC_IMM) ? i_uword.imm : mode_q;

assign host_if.mode_word = {emul, tkk, tr1, tr0, mode_q};

// --------------------
// Exchange memory write port
assign host_if.xmem_we   = exec & (i_uword.ydst == mcu_pkg::YDST_XMEM);
assign host_if.xmem_addr = xptr;
assign host_if.xmem_data = y_bus;

// --------------------
// Y destinations and flag triggers
always_ff @(posedge clk) begin
    if (reset) begin
        mode_q <= '0;
        xptr   <= '0;
        tr0    <= 1'b0;
        tr1    <= 1'b0;
        tkk    <= 1'b0;
        emul   <= 1'b0;
    end else if (exec) begin
        case (i_uword.ydst)
            mcu_pkg::YDST_MODE: mode_q <= y_bus;
            mcu_pkg::YDST_XPTR: xptr <= y_bus[mcu_pkg::XADDR_W-1:0];
            mcu_pkg::YDST_XMEM: xptr <= xptr + 1'b1;    // Post-increment
            default: ;
        endcase
        // Later assignment wins on grp over a mode load
        case (i_uword.ff)
            mcu_pkg::FF_LOGGRP: mode_q[mcu_pkg::MODE_GRP_LO +: 3] <= 3'b001;
            mcu_pkg::FF_MULGRP: mode_q[mcu_pkg::MODE_GRP_LO +: 3] <= 3'b010;
            mcu_pkg::FF_ADDGRP: mode_q[mcu_pkg::MODE_GRP_LO +: 3] <= 3'b100;
            mcu_pkg::FF_CLRTR0: tr0 <= 1'b0;
            mcu_pkg::FF_SETTR0: tr0 <= 1'b1;
            mcu_pkg::FF_CLRTR1: tr1 <= 1'b0;
            mcu_pkg::FF_SETTR1: tr1 <= 1'b1;
            mcu_pkg::FF_CLRTKK: tkk <= 1'b0;
            mcu_pkg::FF_SETTKK: tkk <= 1'b1;
            mcu_pkg::FF_CHTKK:  tkk <= ~tkk;    // Toggle
            mcu_pkg::FF_SETNR:  emul <= 1'b0;   // Native mode
            mcu_pkg::FF_SETER:  emul <= 1'b1;   // Emulation mode
            default: ;
        endcase
    end
end

// --------------------
// Condition multiplexer
always_comb begin
    case (i_uword.cond)
        mcu_pkg::COND_YES:   condmux = 1'b1;
        mcu_pkg::COND_NORMB: condmux = mode_q[mcu_pkg::MODE_NORMB];
        mcu_pkg::COND_RNDB:  condmux = mode_q[mcu_pkg::MODE_RNDB];
        mcu_pkg::COND_OVRIB: condmux = mode_q[mcu_pkg::MODE_OVRIB];
        mcu_pkg::COND_DRG:   condmux = mode_q[mcu_pkg::MODE_DRG];
        mcu_pkg::COND_CB:    condmux = mode_q[mcu_pkg::MODE_CB];
        mcu_pkg::COND_GLOG:  condmux = mode_q[mcu_pkg::MODE_GRP_LO];
        mcu_pkg::COND_GMUL:  condmux = mode_q[mcu_pkg::MODE_GRP_LO + 1];
        mcu_pkg::COND_GADD:  condmux = mode_q[mcu_pkg::MODE_GRP_LO + 2];
        mcu_pkg::COND_TR0:   condmux = tr0;
        mcu_pkg::COND_TR1:   condmux = tr1;
        mcu_pkg::COND_TKK:   condmux = tkk;
        mcu_pkg::COND_EMUL:  condmux = emul;
        default:             condmux = 1'b1;    // Spare codes true
    endcase
end

assign o_cond = condmux ^ ~i_uword.icc;         // icc=1 passes on true

endmodule

/* mcu_pkg.sv */
package mcu_pkg;

// --------------------
// Sizes
localparam int UADDR_W     = 8;     // 256 microwords
localparam int UWORD_W     = 32;    // Microword width
localparam int YBUS_W      = 8;     // Y bus and mode register
localparam int XMEM_DEPTH  = 16;    // Exchange memory bytes
localparam int XADDR_W     = 4;
localparam int STACK_DEPTH = 4;     // Return stack entries

// --------------------
// APB register map
localparam logic [7:0] REG_CTRL      = 8'h00;   // Start/stop, status
localparam logic [7:0] REG_UADDR     = 8'h04;   // Load pointer
localparam logic [7:0] REG_UDATA     = 8'h08;   // Microword at pointer
localparam logic [7:0] REG_MODE      = 8'h0C;   // Mode word readback
localparam logic [7:0] REG_XMEM_BASE = 8'h40;   // Exchange bytes 0x40..0x7C

// --------------------
// Mode register bits
localparam int MODE_NORMB  = 0;     // Normalization block
localparam int MODE_RNDB   = 1;     // Rounding block
localparam int MODE_GRP_LO = 2;     // grp = log, mul, add
localparam int MODE_OVRIB  = 5;     // Overflow interrupt block
localparam int MODE_DRG    = 6;     // Dispatcher mode
localparam int MODE_CB     = 7;     // Address change flag

typedef enum logic [3:0] {
    SEQ_JZ, SEQ_CONT, SEQ_CJP, SEQ_CJS, SEQ_CRTN, SEQ_LDCT, SEQ_RPCT, SEQ_HALT
} seq_op_e;

typedef enum logic [3:0] {
    COND_YES, COND_NORMB, COND_RNDB, COND_OVRIB, COND_DRG, COND_CB, COND_GLOG,
    COND_GMUL, COND_GADD, COND_TR0, COND_TR1, COND_TKK, COND_EMUL
} cond_e;

typedef enum logic [3:0] {
    FF_NOP, FF_LOGGRP, FF_MULGRP, FF_ADDGRP, FF_CLRTR0, FF_SETTR0, FF_CLRTR1,
    FF_SETTR1, FF_CLRTKK, FF_SETTKK, FF_CHTKK, FF_SETNR, FF_SETER
} flag_op_e;

typedef enum logic {YSRC_IMM, YSRC_MODE} ysrc_e;

typedef enum logic [1:0] {YDST_NONE, YDST_MODE, YDST_XPTR, YDST_XMEM} ydst_e;

typedef struct packed {
    seq_op_e      seq;      // Sequencer opcode
    logic [7:0]   addr;     // Branch target or count
    cond_e        cond;     // Condition select
    logic         icc;      // 1 = pass on true
    flag_op_e     ff;       // Flag trigger op
    ysrc_e        ysrc;     // Y bus source
    ydst_e        ydst;     // Y bus destination
    logic [7:0]   imm;      // Immediate
} micro_word_t;

endpackage

/* mcu_sequencer.sv */
`timescale 1ns/100ps

module mcu_sequencer (
    input  logic                        clk,
    input  logic                        reset,
    input  mcu_pkg::micro_word_t        i_uword,
    input  logic                        i_uvalid,
    input  logic                        i_cond,
    output logic [mcu_pkg::UADDR_W-1:0] o_uaddr,
    mcu_host_if.seq                     host_if
);

logic [mcu_pkg::UADDR_W-1:0] uaddr_q;           // Address of word in pipeline
logic [mcu_pkg::UADDR_W-1:0] upc_inc;           // Sequential successor
logic [mcu_pkg::UADDR_W-1:0] next_addr;
logic [mcu_pkg::UADDR_W-1:0] counter;           // Loop counter
logic [mcu_pkg::UADDR_W-1:0] stack [mcu_pkg::STACK_DEPTH];
logic [2:0] sp;                                 // Stack entries used
logic [2:0] sp_top;                             // Index of top entry
logic exec;                                     // Word executes this cycle
logic stack_full;
logic stack_empty;
logic push, pop, halt_op, ld_cnt, dec_cnt;

assign exec        = i_uvalid & host_if.running;
assign upc_inc     = uaddr_q + 1'b1;
assign sp_top      = sp - 1'b1;
assign stack_full  = (sp == 3'(mcu_pkg::STACK_DEPTH));
assign stack_empty = (sp == 3'd0);

// --------------------
// Next address, am2910 subset
always_comb begin
    next_addr = upc_inc;
    push      = 1'b0;
    pop       = 1'b0;
    halt_op   = 1'b0;
    ld_cnt    = 1'b0;
    dec_cnt   = 1'b0;
    case (i_uword.seq)
        mcu_pkg::SEQ_JZ:   next_addr = '0;
        mcu_pkg::SEQ_CONT: next_addr = upc_inc;
        mcu_pkg::SEQ_CJP:  next_addr = i_cond ? i_uword.addr : upc_inc;
        mcu_pkg::SEQ_CJS: begin
            next_addr = i_cond ? i_uword.addr : upc_inc;
            push      = i_cond & ~stack_full;   // Full stack acts as CJP
        end
        mcu_pkg::SEQ_CRTN: begin
            pop       = i_cond & ~stack_empty;  // Empty stack continues
            next_addr = pop ? stack[sp_top[1:0]] : upc_inc;
        end
        mcu_pkg::SEQ_LDCT: ld_cnt = 1'b1;
        mcu_pkg::SEQ_RPCT: begin
            dec_cnt   = (counter != '0);
            next_addr = dec_cnt ? i_uword.addr : upc_inc;
        end
        mcu_pkg::SEQ_HALT: begin
            next_addr = uaddr_q;                // Hold on the halt word
            halt_op   = 1'b1;
        end
        default:           next_addr = upc_inc;
    endcase
end

assign o_uaddr = exec ? next_addr : uaddr_q;    // Refetch until a word executes

// --------------------
// State and run control
always_ff @(posedge clk) begin
    if (reset) begin
        host_if.running <= 1'b0;
        host_if.halted  <= 1'b0;
        uaddr_q         <= '0;
        sp              <= '0;
        counter         <= '0;
    end else if (host_if.start) begin
        host_if.running <= 1'b1;
        host_if.halted  <= 1'b0;
        uaddr_q         <= '0;                  // Program entry
        sp              <= '0;
    end else begin
        if (host_if.running) uaddr_q <= o_uaddr;
        if (host_if.stop) host_if.running <= 1'b0;  // Stop without halted
        if (exec) begin
            if (halt_op) begin
                host_if.running <= 1'b0;
                host_if.halted  <= 1'b1;
            end
            if (push) sp <= sp + 1'b1;
            if (pop) sp <= sp_top;
            if (ld_cnt) counter <= i_uword.addr;
            if (dec_cnt) counter <= counter - 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (exec & push) begin
        stack[sp[1:0]] <= upc_inc;              // Return address
    end
end

endmodule

/* mcu_top.sv */
`timescale 1ns/100ps

module mcu_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        i_psel,         // APB slave port
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [7:0]  i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pslverr
);

logic [mcu_pkg::UADDR_W-1:0] uaddr;     // Sequencer to store
mcu_pkg::micro_word_t        uword;     // Pipeline register
logic                        uvalid;
logic                        cond;      // Mode unit to sequencer

mcu_host_if host_if();

mcu_host_regs u_regs (
    .clk, .reset, .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
    .o_prdata, .o_pslverr, .host_if(host_if.regs)
);

mcu_control_store u_store (
    .clk, .reset, .i_uaddr(uaddr), .o_uword(uword), .o_uvalid(uvalid),
    .host_if(host_if.store)
);

mcu_sequencer u_seq (
    .clk, .reset, .i_uword(uword), .i_uvalid(uvalid), .i_cond(cond),
    .o_uaddr(uaddr), .host_if(host_if.seq)
);

mcu_mode_unit u_unit (
    .clk, .reset, .i_uword(uword), .i_uvalid(uvalid), .o_cond(cond),
    .host_if(host_if.unit)
);

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mcu -f sim.f -o tb_mcu_sim

out=$(./obj_dir/tb_mcu_sim 2>&1 || true)
echo "$out"
echo "$out" | grep -qF "=== PASS ==="

/* sim.f */
+incdir+.
mcu_pkg.sv
mcu_host_if.sv
mcu_host_regs.sv
mcu_control_store.sv
mcu_sequencer.sv
mcu_mode_unit.sv
mcu_top.sv
tb_mcu.sv

/* tb_apb_tasks.svh */
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// --------------------
// APB master, zero wait states
task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    @(negedge clk);
    psel    = 1'b1;                                 // Setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;                                 // Access phase
    #(CLK_PERIOD / 4);
    check_value($sformatf("o_pslverr @0x%02h", addr), {31'd0, pslverr}, {31'd0, exp_err});
    @(negedge clk);
    psel    = 1'b0;                                 // Back to idle
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    data = prdata;                                  // Mid access phase, settled
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
endtask

// --------------------
// Microword assembly, field order from the top bit down
function automatic logic [31:0] pack_uword(
    input mcu_pkg::seq_op_e  seq,
    input logic [7:0]        addr,
    input mcu_pkg::cond_e    cond,
    input logic              icc,
    input mcu_pkg::flag_op_e ff,
    input mcu_pkg::ysrc_e    ysrc,
    input mcu_pkg::ydst_e    ydst,
    input logic [7:0]        imm
);
    return {seq, addr, cond, icc, ff, ysrc, ydst, imm};   // 4+8+4+1+4+1+2+8
endfunction

function automatic logic [31:0] cont_word(
    input mcu_pkg::flag_op_e ff,
    input mcu_pkg::ysrc_e    ysrc,
    input mcu_pkg::ydst_e    ydst,
    input logic [7:0]        imm
);
    return pack_uword(mcu_pkg::SEQ_CONT, 8'd0, mcu_pkg::COND_YES, 1'b1, ff, ysrc, ydst, imm);
endfunction

function automatic logic [31:0] branch_word(
    input mcu_pkg::seq_op_e seq,
    input logic [7:0]       addr,
    input mcu_pkg::cond_e   cond,
    input logic             icc
);
    return pack_uword(seq, addr, cond, icc, mcu_pkg::FF_NOP, mcu_pkg::YSRC_IMM,
                      mcu_pkg::YDST_NONE, 8'd0);
endfunction

function automatic logic [31:0] xmem_word(input logic [7:0] imm);
    return cont_word(mcu_pkg::FF_NOP, mcu_pkg::YSRC_IMM, mcu_pkg::YDST_XMEM, imm);
endfunction

function automatic logic [31:0] halt_word();
    return branch_word(mcu_pkg::SEQ_HALT, 8'd0, mcu_pkg::COND_YES, 1'b1);
endfunction

`endif

/* tb_mcu.sv */
`timescale 1ns/100ps

module tb_mcu;

localparam int CLK_PERIOD = 100;
localparam int POLL_LIMIT = 200;                    // CTRL reads before giving up
localparam int LOOP_N     = 3;                      // Repeat count for the loop test

logic        clk;
logic        reset;
logic        psel;
logic        penable;
logic        pwrite;
logic [7:0]  paddr;
logic [31:0] pwdata;
logic [31:0] prdata;
logic        pslverr;

integer      seed;
logic [31:0] prog [$];                              // Program being assembled
logic [31:0] rdata;
logic [7:0]  rnd [4];
logic [7:0]  loop_imm;
logic [7:0]  mode_imm;
logic [7:0]  mode_exp;

mcu_top i_dut (
    .clk, .reset, .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
    .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata), .o_pslverr(pslverr)
);

always #(CLK_PERIOD / 2) clk = ~clk;

// --------------------
// Checking
task automatic fail_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on first error");
endtask

task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    assert (act === exp)
    else fail_run($sformatf("[ERROR] t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, act));
endtask

`include "tb_apb_tasks.svh"

task automatic check_xmem(input int idx, input logic [7:0] exp);
    logic [31:0] d;
    apb_read(mcu_pkg::REG_XMEM_BASE + 8'(idx * 4), d);
    check_value($sformatf("xmem[%0d]", idx), d, {24'd0, exp});
endtask

task automatic wait_ctrl_bit(input int bitpos, input string what);
    logic [31:0] d;
    int          n;
    d = '0;
    n = 0;
    while (!d[bitpos] && n < POLL_LIMIT) begin
        apb_read(mcu_pkg::REG_CTRL, d);
        n++;
    end
    if (!d[bitpos]) fail_run($sformatf("Timeout while waiting for %s", what));
endtask

task automatic load_program();
    apb_write(mcu_pkg::REG_UADDR, 32'd0, 1'b0);     // Programs start at 0
    foreach (prog[i]) apb_write(mcu_pkg::REG_UDATA, prog[i], 1'b0);
    prog.delete();
endtask

task automatic run_program();
    apb_write(mcu_pkg::REG_CTRL, 32'h1, 1'b0);      // Start
    wait_ctrl_bit(1, "halted");
    apb_read(mcu_pkg::REG_CTRL, rdata);
    check_value("CTRL after halt", rdata, 32'h2);   // Halted and not running
endtask

// --------------------
// Stimulus
initial begin
    seed    = 32'h4c46_377f;
    clk     = 1'b0;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    // Reset state
    apb_read(mcu_pkg::REG_CTRL, rdata);
    check_value("CTRL after reset", rdata, 32'h0);
    apb_read(mcu_pkg::REG_MODE, rdata);
    check_value("MODE after reset", rdata, 32'h0);
    for (int i = 0; i < 16; i++) check_xmem(i, 8'h00);

    // Straight line writing four bytes from pointer 2
    for (int i = 0; i < 4; i++) rnd[i] = 8'($random(seed));
    prog.push_back(cont_word(mcu_pkg::FF_NOP, mcu_pkg::YSRC_IMM, mcu_pkg::YDST_XPTR, 8'd2));
    for (int i = 0; i < 4; i++) prog.push_back(xmem_word(rnd[i]));
    prog.push_back(halt_word());
    load_program();
    run_program();
    for (int i = 0; i < 4; i++) check_xmem(2 + i, rnd[i]);

    // Conditions with icc and markers A1 A2 A3 at bytes 6..8
    prog.push_back(cont_word(mcu_pkg::FF_SETTR0, mcu_pkg::YSRC_IMM, mcu_pkg::YDST_XPTR, 8'd6));
    prog.push_back(branch_word(mcu_pkg::SEQ_CJP, 8'd3, mcu_pkg::COND_TR0, 1'b1));  // Taken
    prog.push_back(xmem_word(8'hE1));
    prog.push_back(xmem_word(8'hA1));
    prog.push_back(branch_word(mcu_pkg::SEQ_CJP, 8'd6, mcu_pkg::COND_TR1, 1'b1));  // Not taken
    prog.push_back(xmem_word(8'hA2));
    prog.push_back(branch_word(mcu_pkg::SEQ_CJP, 8'd8, mcu_pkg::COND_TR1, 1'b0));  // Inverted
    prog.push_back(xmem_word(8'hE2));
    prog.push_back(xmem_word(8'hA3));
    prog.push_back(halt_word());
    load_program();
    run_program();
    check_xmem(6, 8'hA1);
    check_xmem(7, 8'hA2);
    check_xmem(8, 8'hA3);
    check_xmem(9, 8'h00);                           // Nothing past the last marker

    // Repeat loop calling a subroutine for n+1 passes from byte 9
    loop_imm = 8'($random(seed));
    prog.push_back(pack_uword(mcu_pkg::SEQ_LDCT, 8'(LOOP_N), mcu_pkg::COND_YES, 1'b1,
                              mcu_pkg::FF_NOP, mcu_pkg::YSRC_IMM, mcu_pkg::YDST_XPTR, 8'd9));
    prog.push_back(branch_word(mcu_pkg::SEQ_CJS, 8'd5, mcu_pkg::COND_YES, 1'b1));
    prog.push_back(branch_word(mcu_pkg::SEQ_RPCT, 8'd1, mcu_pkg::COND_YES, 1'b1));
    prog.push_back(xmem_word(8'hB0));               // Post-loop marker
    prog.push_back(halt_word());
    prog.push_back(xmem_word(loop_imm));            // Subroutine body
    prog.push_back(branch_word(mcu_pkg::SEQ_CRTN, 8'd0, mcu_pkg::COND_YES, 1'b1));
    load_program();
    run_program();
    for (int i = 0; i <= LOOP_N; i++) check_xmem(9 + i, loop_imm);
    check_xmem(10 + LOOP_N, 8'hB0);
    check_xmem(11 + LOOP_N, 8'h00);

    // Mode load with grp override followed by TKK and EMUL ops and a mode copy to byte 14
    mode_imm = 8'($random(seed));
    mode_exp = (mode_imm & 8'hE3) | 8'h08;          // grp forced to mul
    prog.push_back(cont_word(mcu_pkg::FF_MULGRP, mcu_pkg::YSRC_IMM, mcu_pkg::YDST_MODE, mode_imm));
    prog.push_back(cont_word(mcu_pkg::FF_SETTKK, mcu_pkg::YSRC_IMM, mcu_pkg::YDST_XPTR, 8'd14));
    prog.push_back(cont_word(mcu_pkg::FF_CHTKK, mcu_pkg::YSRC_IMM, mcu_pkg::YDST_NONE, 8'd0));
    prog.push_back(cont_word(mcu_pkg::FF_SETER, mcu_pkg::YSRC_IMM, mcu_pkg::YDST_NONE, 8'd0));
    prog.push_back(cont_word(mcu_pkg::FF_CLRTR0, mcu_pkg::YSRC_MODE, mcu_pkg::YDST_XMEM, 8'd0));
    prog.push_back(halt_word());
    load_program();
    run_program();
    apb_read(mcu_pkg::REG_MODE, rdata);
    check_value("REG_MODE", rdata, {20'd0, 4'b1000, mode_exp});   // EMUL only
    check_xmem(14, mode_exp);

    // Self loop with load attempts while running and a final stop
    prog.push_back(branch_word(mcu_pkg::SEQ_JZ, 8'd0, mcu_pkg::COND_YES, 1'b1));
    load_program();
    apb_write(mcu_pkg::REG_UADDR, 32'd0, 1'b0);     // Pointer back on the loop word
    apb_write(mcu_pkg::REG_CTRL, 32'h1, 1'b0);
    wait_ctrl_bit(0, "running");
    apb_write(mcu_pkg::REG_UADDR, 32'd0, 1'b1);
    apb_write(mcu_pkg::REG_UDATA, halt_word(), 1'b1);   // Would halt if stored
    repeat (4) @(negedge clk);
    apb_read(mcu_pkg::REG_CTRL, rdata);
    check_value("CTRL while looping", rdata, 32'h1);
    apb_write(mcu_pkg::REG_CTRL, 32'h2, 1'b0);      // Stop
    apb_read(mcu_pkg::REG_CTRL, rdata);
    check_value("CTRL after stop", rdata, 32'h0);

    $display("=== PASS ===");
    $finish;
end

endmodule
